//--- design/exu_pkg.sv
package exu_pkg;

    localparam int xlen       = 64;
    localparam int word_width = 32;
    localparam int alu_op_w   = 5;

    typedef enum logic [alu_op_w-1:0] {
        op_add     = 5'd0,
        op_sub     = 5'd1,
        op_lt      = 5'd2,
        op_ltu     = 5'd3,
        op_and     = 5'd4,
        op_or      = 5'd5,
        op_xor     = 5'd6,
        op_sll     = 5'd7,
        op_srl     = 5'd8,
        op_sra     = 5'd9,
        op_out_imm = 5'd10, // Passes operator 2 through.
        op_eq      = 5'd11,
        op_ne      = 5'd12,
        op_ge      = 5'd13,
        op_geu     = 5'd14,
        op_addw    = 5'd15,
        op_sllw    = 5'd16,
        op_srlw    = 5'd17,
        op_sraw    = 5'd18,
        op_subw    = 5'd19
    } alu_op_e;

    // Operand 1 source.
    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    // Operand 2 source.
    typedef enum logic [1:0] {
        src2_rs2  = 2'd0,
        src2_imm  = 2'd1,
        src2_four = 2'd2
    } src2_sel_e;

    // Control transfer kind.
    typedef enum logic [1:0] {
        br_none = 2'd0, // Never taken.
        br_cond = 2'd1, // Taken on ALU result bit 0.
        br_jal  = 2'd2, // Target pc + imm.
        br_jalr = 2'd3  // Target rs1 + imm, bit 0 cleared.
    } br_kind_e;

endpackage

//--- design/mux_key.sv
`timescale 1ns/1ns

module mux_key #(
    parameter int nr_key   = 2,
    parameter int key_len  = 1,
    parameter int data_len = 1
) (
    input  logic [key_len-1:0]                  key,
    input  logic [data_len-1:0]                 default_out,
    input  logic [nr_key*(key_len+data_len)-1:0] lut,
    output logic [data_len-1:0]                 out
);

    localparam int pair_len = key_len + data_len;

    logic [key_len-1:0]  key_list  [nr_key];
    logic [data_len-1:0] data_list [nr_key];

    // Entry 0 sits in the top bits of the table.
    for (genvar i = 0; i < nr_key; i++) begin : g_unpack
        assign key_list[i]  = lut[(nr_key-i)*pair_len-1 -: key_len];
        assign data_list[i] = lut[(nr_key-i)*pair_len-key_len-1 -: data_len];
    end

    // Earliest matching entry wins.
    always_comb begin
        out = default_out;
        for (int j = nr_key - 1; j >= 0; j--) begin
            if (key == key_list[j]) begin
                out = data_list[j];
            end
        end
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [exu_pkg::xlen-1:0] operator_1,
    input  logic [exu_pkg::xlen-1:0] operator_2,
    input  exu_pkg::alu_op_e         alu_op,
    output logic [exu_pkg::xlen-1:0] alu_result
);

    localparam int xw = exu_pkg::xlen;
    localparam int ww = exu_pkg::word_width;

    logic [5:0]    shamt;
    logic [4:0]    shamt_w;
    logic [ww-1:0] op1_w;
    logic [ww-1:0] op2_w;

    logic [xw-1:0] sum;
    logic [xw-1:0] diff;
    logic [xw-1:0] sll_res;
    logic [xw-1:0] srl_res;
    logic [xw-1:0] sra_res;
    logic [xw-1:0] lt_res;
    logic [xw-1:0] ltu_res;
    logic [xw-1:0] eq_res;
    logic [xw-1:0] ne_res;
    logic [xw-1:0] ge_res;
    logic [xw-1:0] geu_res;

    logic [ww-1:0] addw_w;
    logic [ww-1:0] subw_w;
    logic [ww-1:0] sllw_w;
    logic [ww-1:0] srlw_w;
    logic [ww-1:0] sraw_w;

    assign shamt   = operator_2[5:0];
    assign shamt_w = operator_2[4:0];
    assign op1_w   = operator_1[ww-1:0];
    assign op2_w   = operator_2[ww-1:0];

    assign sum     = operator_1 + operator_2;
    assign diff    = operator_1 - operator_2;
    assign sll_res = operator_1 << shamt;
    assign srl_res = operator_1 >> shamt;
    assign sra_res = $signed(operator_1) >>> shamt;

    // Compare flags, zero extended.
    assign lt_res  = {{(xw-1){1'b0}}, $signed(operator_1) < $signed(operator_2)};
    assign ltu_res = {{(xw-1){1'b0}}, operator_1 < operator_2};
    assign eq_res  = {{(xw-1){1'b0}}, operator_1 == operator_2};
    assign ne_res  = {{(xw-1){1'b0}}, operator_1 != operator_2};
    assign ge_res  = {{(xw-1){1'b0}}, $signed(operator_1) >= $signed(operator_2)};
    assign geu_res = {{(xw-1){1'b0}}, operator_1 >= operator_2};

    assign addw_w = op1_w + op2_w;
    assign subw_w = op1_w - op2_w;
    assign sllw_w = op1_w << shamt_w;
    assign srlw_w = op1_w >> shamt_w;
    assign sraw_w = $signed(op1_w) >>> shamt_w; // Fills from bit 31.

    mux_key #(
        .nr_key   (20),
        .key_len  (exu_pkg::alu_op_w),
        .data_len (xw)
    ) result_mux_i (
        .key         (alu_op),
        .default_out ('0),
        .lut ({
            exu_pkg::op_add,     sum,
            exu_pkg::op_sub,     diff,
            exu_pkg::op_lt,      lt_res,
            exu_pkg::op_ltu,     ltu_res,
            exu_pkg::op_and,     operator_1 & operator_2,
            exu_pkg::op_or,      operator_1 | operator_2,
            exu_pkg::op_xor,     operator_1 ^ operator_2,
            exu_pkg::op_sll,     sll_res,
            exu_pkg::op_srl,     srl_res,
            exu_pkg::op_sra,     sra_res,
            exu_pkg::op_out_imm, operator_2,
            exu_pkg::op_eq,      eq_res,
            exu_pkg::op_ne,      ne_res,
            exu_pkg::op_ge,      ge_res,
            exu_pkg::op_geu,     geu_res,
            exu_pkg::op_addw,    {{(xw-ww){addw_w[ww-1]}}, addw_w},
            exu_pkg::op_sllw,    {{(xw-ww){sllw_w[ww-1]}}, sllw_w},
            exu_pkg::op_srlw,    {{(xw-ww){srlw_w[ww-1]}}, srlw_w},
            exu_pkg::op_sraw,    {{(xw-ww){sraw_w[ww-1]}}, sraw_w},
            exu_pkg::op_subw,    {{(xw-ww){subw_w[ww-1]}}, subw_w}
        }),
        .out         (alu_result)
    );

endmodule

//--- design/exu_operand_sel.sv
`timescale 1ns/1ns

module exu_operand_sel (
    input  exu_pkg::src1_sel_e       src1_sel,
    input  exu_pkg::src2_sel_e       src2_sel,
    input  logic [exu_pkg::xlen-1:0] rs1_data,
    input  logic [exu_pkg::xlen-1:0] rs2_data,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  logic [exu_pkg::xlen-1:0] pc,
    output logic [exu_pkg::xlen-1:0] operator_1,
    output logic [exu_pkg::xlen-1:0] operator_2
);

    localparam logic [exu_pkg::xlen-1:0] zero_val = '0;
    localparam logic [exu_pkg::xlen-1:0] four_val = 4; // Link offset.

    mux_key #(
        .nr_key   (3),
        .key_len  ($bits(exu_pkg::src1_sel_e)),
        .data_len (exu_pkg::xlen)
    ) src1_mux_i (
        .key         (src1_sel),
        .default_out (zero_val),
        .lut ({
            exu_pkg::src1_rs1,  rs1_data,
            exu_pkg::src1_pc,   pc,
            exu_pkg::src1_zero, zero_val
        }),
        .out         (operator_1)
    );

    // Unused select code falls back to rs2.
    mux_key #(
        .nr_key   (3),
        .key_len  ($bits(exu_pkg::src2_sel_e)),
        .data_len (exu_pkg::xlen)
    ) src2_mux_i (
        .key         (src2_sel),
        .default_out (rs2_data),
        .lut ({
            exu_pkg::src2_rs2,  rs2_data,
            exu_pkg::src2_imm,  imm,
            exu_pkg::src2_four, four_val
        }),
        .out         (operator_2)
    );

endmodule

//--- design/exu_branch.sv
`timescale 1ns/1ns

module exu_branch (
    input  exu_pkg::br_kind_e        br_kind,
    input  logic [exu_pkg::xlen-1:0] alu_result,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1_data,
    input  logic [exu_pkg::xlen-1:0] imm,
    output logic                     br_taken,
    output logic [exu_pkg::xlen-1:0] next_pc
);

    logic [exu_pkg::xlen-1:0] target_base;
    logic [exu_pkg::xlen-1:0] target_sum;
    logic [exu_pkg::xlen-1:0] target;
    logic [exu_pkg::xlen-1:0] seq_pc;

    // Only jalr takes its base from rs1.
    assign target_base = (br_kind == exu_pkg::br_jalr) ? rs1_data : pc;
    assign target_sum  = target_base + imm;
    assign seq_pc      = pc + exu_pkg::xlen'(4);

    always_comb begin
        target = target_sum;
        if (br_kind == exu_pkg::br_jalr) begin
            target[0] = 1'b0; // Jalr clears the low bit.
        end
    end

    always_comb begin
        unique case (br_kind)
            exu_pkg::br_none: begin
                br_taken = 1'b0;
            end
            exu_pkg::br_cond: begin
                br_taken = alu_result[0]; // Compare flag from the ALU.
            end
            exu_pkg::br_jal,
            exu_pkg::br_jalr: begin
                br_taken = 1'b1;
            end
            default: begin
                br_taken = 1'b0;
            end
        endcase
    end

    assign next_pc = br_taken ? target : seq_pc;

endmodule

//--- design/exu_top.sv
`timescale 1ns/1ns

module exu_top (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     in_valid,
    output logic                     in_ready,
    input  exu_pkg::alu_op_e         alu_op,
    input  exu_pkg::src1_sel_e       src1_sel,
    input  exu_pkg::src2_sel_e       src2_sel,
    input  exu_pkg::br_kind_e        br_kind,
    input  logic [exu_pkg::xlen-1:0] rs1_data,
    input  logic [exu_pkg::xlen-1:0] rs2_data,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  logic [exu_pkg::xlen-1:0] pc,

    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [exu_pkg::xlen-1:0] result,
    output logic                     br_taken,
    output logic [exu_pkg::xlen-1:0] next_pc
);

    logic [exu_pkg::xlen-1:0] operator_1;
    logic [exu_pkg::xlen-1:0] operator_2;
    logic [exu_pkg::xlen-1:0] alu_result;
    logic                     br_taken_d;
    logic [exu_pkg::xlen-1:0] next_pc_d;
    logic                     accept;

    exu_operand_sel operand_sel_i (
        .src1_sel   (src1_sel),
        .src2_sel   (src2_sel),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc         (pc),
        .operator_1 (operator_1),
        .operator_2 (operator_2)
    );

    alu alu_i (
        .operator_1 (operator_1),
        .operator_2 (operator_2),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    exu_branch branch_i (
        .br_kind    (br_kind),
        .alu_result (alu_result),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .imm        (imm),
        .br_taken   (br_taken_d),
        .next_pc    (next_pc_d)
    );

    // Register can take a new entry when empty or draining this edge.
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0; // Drained with no refill.
        end
    end

    // Payload holds while stalled.
    always_ff @(posedge clk) begin
        if (accept) begin
            result   <= alu_result;
            br_taken <= br_taken_d;
            next_pc  <= next_pc_d;
        end
    end

endmodule

//--- dv/exu_assert.sv
`timescale 1ns/1ns

module exu_assert (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              in_valid,
    input logic                              in_ready,
    input logic [exu_pkg::alu_op_w-1:0]      alu_op,
    input logic [1:0]                        src1_sel,
    input logic [1:0]                        src2_sel,
    input logic [1:0]                        br_kind,
    input logic [exu_pkg::xlen-1:0]          rs1_data,
    input logic [exu_pkg::xlen-1:0]          rs2_data,
    input logic [exu_pkg::xlen-1:0]          imm,
    input logic [exu_pkg::xlen-1:0]          pc,
    input logic                              out_valid,
    input logic                              out_ready,
    input logic [exu_pkg::xlen-1:0]          result,
    input logic                              br_taken,
    input logic [exu_pkg::xlen-1:0]          next_pc
);

    localparam int xw = exu_pkg::xlen;

    int unsigned error_count = 0;

    logic [xw-1:0] op_a;
    logic [xw-1:0] op_b;
    logic [xw-1:0] exp_result;
    logic [xw-1:0] exp_next_pc;
    logic          exp_taken;
    logic          accept;

    function automatic logic [xw-1:0] sext_word(input logic [31:0] w);
        return {{(xw-32){w[31]}}, w};
    endfunction

    function automatic logic [xw-1:0] alu_ref(input logic [4:0] op,
                                              input logic [xw-1:0] a,
                                              input logic [xw-1:0] b);
        logic [31:0] fill;
        fill = ~(32'hffff_ffff >> b[4:0]); // Bits vacated by a word shift.
        case (op)
            exu_pkg::op_add:     return a + b;
            exu_pkg::op_sub:     return a - b;
            exu_pkg::op_lt:      return ($signed(a) < $signed(b)) ? 1 : 0;
            exu_pkg::op_ltu:     return (a < b) ? 1 : 0;
            exu_pkg::op_and:     return a & b;
            exu_pkg::op_or:      return a | b;
            exu_pkg::op_xor:     return a ^ b;
            exu_pkg::op_sll:     return a << b[5:0];
            exu_pkg::op_srl:     return a >> b[5:0];
            exu_pkg::op_sra:     return $signed(a) >>> b[5:0];
            exu_pkg::op_out_imm: return b;
            exu_pkg::op_eq:      return (a == b) ? 1 : 0;
            exu_pkg::op_ne:      return (a != b) ? 1 : 0;
            exu_pkg::op_ge:      return ($signed(a) >= $signed(b)) ? 1 : 0;
            exu_pkg::op_geu:     return (a >= b) ? 1 : 0;
            exu_pkg::op_addw:    return sext_word(a[31:0] + b[31:0]);
            exu_pkg::op_sllw:    return sext_word(a[31:0] << b[4:0]);
            exu_pkg::op_srlw:    return sext_word(a[31:0] >> b[4:0]);
            exu_pkg::op_sraw:    return sext_word((a[31:0] >> b[4:0]) | (a[31] ? fill : 32'h0));
            exu_pkg::op_subw:    return sext_word(a[31:0] - b[31:0]);
            default:             return '0;
        endcase
    endfunction

    // Reference model of the stage for the current input.
    always_comb begin
        op_a = (src1_sel == exu_pkg::src1_rs1) ? rs1_data :
               (src1_sel == exu_pkg::src1_pc)  ? pc : '0;
        op_b = (src2_sel == exu_pkg::src2_imm)  ? imm :
               (src2_sel == exu_pkg::src2_four) ? xw'(4) : rs2_data;
        exp_result = alu_ref(alu_op, op_a, op_b);
        exp_taken  = (br_kind == exu_pkg::br_cond) ? exp_result[0] :
                     ((br_kind == exu_pkg::br_jal) || (br_kind == exu_pkg::br_jalr));
        exp_next_pc = !exp_taken ? pc + xw'(4) :
                      (br_kind == exu_pkg::br_jalr) ? ((rs1_data + imm) & ~xw'(1)) : pc + imm;
        accept = in_valid && in_ready;
    end

    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid && in_ready)
        else begin
            error_count++;
            $error("** Error %0t: output side not idle after reset", $time);
        end

    one_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> out_valid)
        else begin
            error_count++;
            $error("** Error %0t: out_valid low after an accepted input", $time);
        end

    result_match: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> result == $past(exp_result))
        else begin
            error_count++;
            $error("** Error %0t: result differs from the model", $time);
        end

    branch_match: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> br_taken == $past(exp_taken) && next_pc == $past(exp_next_pc))
        else begin
            error_count++;
            $error("** Error %0t: br_taken or next_pc differs from the model", $time);
        end

    stall_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |-> !in_ready)
        else begin
            error_count++;
            $error("** Error %0t: in_ready high while the output is stalled", $time);
        end

    stall_holds_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(br_taken)
            && $stable(next_pc))
        else begin
            error_count++;
            $error("** Error %0t: output changed while stalled", $time);
        end

    full_rate: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && out_ready |-> in_ready)
        else begin
            error_count++;
            $error("** Error %0t: in_ready low with out_ready high", $time);
        end

endmodule

bind exu_top exu_assert checks_i (.*);

//--- dv/exu_tb.sv
`timescale 1ns/1ns

module exu_tb;

    localparam int xw         = exu_pkg::xlen;
    localparam int n_txn      = 600;
    localparam int wait_limit = 200;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    exu_pkg::alu_op_e   alu_op;
    exu_pkg::src1_sel_e src1_sel;
    exu_pkg::src2_sel_e src2_sel;
    exu_pkg::br_kind_e  br_kind;
    logic [xw-1:0]      rs1_data;
    logic [xw-1:0]      rs2_data;
    logic [xw-1:0]      imm;
    logic [xw-1:0]      pc;
    logic               out_valid;
    logic               out_ready;
    logic [xw-1:0]      result;
    logic               br_taken;
    logic [xw-1:0]      next_pc;

    logic [63:0]        rng_state;
    int unsigned        ready_left;

    exu_top exu_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .alu_op    (alu_op),
        .src1_sel  (src1_sel),
        .src2_sel  (src2_sel),
        .br_kind   (br_kind),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .pc        (pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .br_taken  (br_taken),
        .next_pc   (next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    task automatic next_rand(output logic [63:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic fail_run(input string why);
        $display("sim failed");
        $fatal(1, why);
    endtask

    // Random value with corner cases mixed in.
    task automatic pick_operand(output logic [xw-1:0] value);
        logic [63:0] r;
        next_rand(r);
        case (r[2:0])
            3'd0: value = '0;
            3'd1: value = '1;
            3'd2: value = {1'b1, {(xw-1){1'b0}}};
            3'd3: value = {r[63:32], 1'b1, r[30:0]};
            default: next_rand(value);
        endcase
    endtask

    // One clock edge; out_ready follows random high and low stretches.
    task automatic advance_clock();
        logic [63:0] r;
        @(posedge clk);
        if (ready_left == 0) begin
            next_rand(r);
            if (r[1:0] != 2'd0) begin
                out_ready <= 1'b1;
                ready_left = 1 + r[7:4];
            end else begin
                out_ready <= 1'b0;
                ready_left = 1 + r[5:4];
            end
        end else begin
            ready_left--;
        end
    endtask

    task automatic drive_instr();
        logic [63:0]      r;
        logic [xw-1:0]    v;
        exu_pkg::alu_op_e op;
        next_rand(r);
        op = exu_pkg::alu_op_e'(r[12:8] % 20);
        if (r[25:24] == 2'd1 && r[26]) begin
            op = r[27] ? exu_pkg::alu_op_e'(2 + r[28]) : exu_pkg::alu_op_e'(11 + r[29:28]);
        end
        in_valid <= 1'b1;
        alu_op   <= op;
        src1_sel <= exu_pkg::src1_sel_e'(r[20:16] % 3);
        src2_sel <= exu_pkg::src2_sel_e'(r[23:21] % 3);
        br_kind  <= exu_pkg::br_kind_e'(r[25:24]);
        pick_operand(v);
        rs1_data <= v;
        pick_operand(v);
        rs2_data <= v;
        pick_operand(v);
        imm <= v;
        pick_operand(v);
        pc <= v;
    endtask

    // Returns at the negedge before the edge that takes the input.
    task automatic wait_in_ready();
        int unsigned cycles;
        cycles = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (cycles == wait_limit) fail_run("timeout waiting for in_ready");
            advance_clock();
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_drained();
        int unsigned cycles;
        cycles = 0;
        @(negedge clk);
        while (out_valid) begin
            if (cycles == wait_limit) fail_run("timeout waiting for the output to drain");
            advance_clock();
            @(negedge clk);
            cycles++;
        end
    endtask

    always @(negedge clk) begin
        if (exu_top_i.checks_i.error_count != 0) begin
            fail_run("an assertion in exu_assert failed");
        end
    end

    initial begin
        logic [63:0] r;
        int unsigned accepted;
        rng_state  = 64'd19;
        ready_left = 24; // Full-rate stretch first.
        accepted   = 0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        alu_op     = exu_pkg::op_add;
        src1_sel   = exu_pkg::src1_rs1;
        src2_sel   = exu_pkg::src2_rs2;
        br_kind    = exu_pkg::br_none;
        rs1_data   = '0;
        rs2_data   = '0;
        imm        = '0;
        pc         = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (accepted < n_txn) begin
            next_rand(r);
            if (r[3:0] == 4'd0) begin
                in_valid <= 1'b0; // Idle gap.
                advance_clock();
            end
            drive_instr();
            wait_in_ready();
            advance_clock();
            accepted++;
        end
        in_valid <= 1'b0;
        wait_drained();
        advance_clock();
        advance_clock();
        @(negedge clk);
        if (exu_top_i.checks_i.error_count != 0) begin
            fail_run("assertion errors were counted");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- tb.f
design/exu_pkg.sv
design/mux_key.sv
design/alu.sv
design/exu_operand_sel.sv
design/exu_branch.sv
design/exu_top.sv
dv/exu_assert.sv
dv/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - design/exu_pkg.sv
  - design/mux_key.sv
  - design/alu.sv
  - design/exu_operand_sel.sv
  - design/exu_branch.sv
  - design/exu_top.sv
  - target: simulation
    files:
      - dv/exu_assert.sv
      - dv/exu_tb.sv
